// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_cpu_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS := $(wildcard *.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: alu32.sv
`timescale 1ns/1ns

module alu32 (
  input  cpu_isa_pkg::opcode_e            op,
  input  cpu_isa_pkg::sub_op_e            sub_op,
  input  logic [cpu_isa_pkg::data_w-1:0]  src1,
  input  logic [cpu_isa_pkg::data_w-1:0]  src2,
  input  logic [cpu_isa_pkg::data_w-1:0]  imm,
  output logic [cpu_isa_pkg::data_w-1:0]  result
);
  import cpu_isa_pkg::*;

  logic [data_w-1:0] operand2;

  // Only register-type operations use the second register
  assign operand2 = (op == op_alu) ? src2 : imm;

  always_comb begin
    result = '0;
    case (op)
      op_alu: begin
        case (sub_op)
          sub_add: result = src1 + operand2;
          sub_sub: result = src1 - operand2;
          sub_and: result = src1 & operand2;
          sub_or:  result = src1 | operand2;
          sub_xor: result = src1 ^ operand2;
          default: result = '0;
        endcase
      end
      op_addi, op_lwi, op_swi: result = src1 + operand2; // Loads and stores form the address here
      op_ori:  result = src1 | operand2;
      default: result = '0;
    endcase
  end

endmodule

// File: cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  typedef enum logic [1:0] {
    ld_idle,
    ld_read,
    ld_write
  } load_state_e;

  typedef enum logic [2:0] {
    ex_idle,
    ex_fetch,
    ex_decode,
    ex_execute,
    ex_mem,
    ex_write
  } exec_state_e;

  localparam int cycle_w = 64;
  localparam int ins_w   = 32;

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

  localparam int data_w     = 32;
  localparam int reg_addr_w = 5;

  ////////////////////
  // Instruction fields
  ////////////////////
  localparam int op_w   = 6;
  localparam int sub_w  = 5;
  localparam int imm_w  = 15;
  localparam int op_lsb = 26;
  localparam int rt_lsb = 21;
  localparam int ra_lsb = 16;
  localparam int rb_lsb = 11;

  // Major opcode in bits 31 to 26
  typedef enum logic [op_w-1:0] {
    op_lwi  = 6'b000010,
    op_swi  = 6'b001010,
    op_alu  = 6'b100000,
    op_addi = 6'b101000,
    op_ori  = 6'b101100
  } opcode_e;

  typedef enum logic [sub_w-1:0] {
    sub_add = 5'b00000,
    sub_sub = 5'b00001,
    sub_and = 5'b00010,
    sub_xor = 5'b00011,
    sub_or  = 5'b00100
  } sub_op_e; // Only decoded when opcode is op_alu

endpackage

// File: cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
  parameter int im_addr_w  = 10,
  parameter int rom_addr_w = 8,
  parameter int dm_addr_w  = 12
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              system_enable,
  input  logic [cpu_isa_pkg::data_w:0]      rom_out,
  input  logic [cpu_isa_pkg::data_w-1:0]    dm_out,
  output logic                              rom_enable,
  output logic                              rom_read,
  output logic [rom_addr_w-1:0]             rom_address,
  output logic                              dm_enable,
  output logic                              dm_read,
  output logic                              dm_write,
  output logic [dm_addr_w-1:0]              dm_address,
  output logic [cpu_isa_pkg::data_w-1:0]    dm_in,
  output logic [cpu_ctrl_pkg::cycle_w-1:0]  cycle_cnt,
  output logic [cpu_ctrl_pkg::ins_w-1:0]    ins_cnt,
  output logic                              done
);
  import cpu_isa_pkg::*;

  ////////////////////
  // Load path
  ////////////////////
  logic                  im_write;
  logic [im_addr_w-1:0]  im_waddr;
  logic [data_w-1:0]     im_wdata;
  logic                  load_done;
  logic [im_addr_w:0]    total_ir;
  logic                  run_active;

  ////////////////////
  // Execute path
  ////////////////////
  logic                  im_read;
  logic [im_addr_w-1:0]  im_raddr;
  logic [data_w-1:0]     im_rdata;
  logic [reg_addr_w-1:0] reg_raddr1;
  logic [reg_addr_w-1:0] reg_raddr2;
  logic                  reg_write;
  logic [reg_addr_w-1:0] reg_waddr;
  logic [data_w-1:0]     reg_wdata;
  logic [data_w-1:0]     read_data1;
  logic [data_w-1:0]     read_data2;
  opcode_e               alu_op;
  sub_op_e               alu_sub_op;
  logic [data_w-1:0]     alu_src1;
  logic [data_w-1:0]     alu_src2;
  logic [data_w-1:0]     alu_imm;
  logic [data_w-1:0]     alu_result;

  rom_loader #(.im_addr_w(im_addr_w), .rom_addr_w(rom_addr_w)) rom_loader_i (.*);

  instr_mem #(.im_addr_w(im_addr_w)) instr_mem_i (.*);

  ir_controller #(.im_addr_w(im_addr_w), .dm_addr_w(dm_addr_w)) ir_controller_i (.*);

  regfile regfile_i (
    .clk        (clk),
    .rst        (rst),
    .raddr1     (reg_raddr1),
    .raddr2     (reg_raddr2),
    .write      (reg_write),
    .waddr      (reg_waddr),
    .wdata      (reg_wdata),
    .read_data1 (read_data1),
    .read_data2 (read_data2)
  );

  alu32 alu32_i (
    .op     (alu_op),
    .sub_op (alu_sub_op),
    .src1   (alu_src1),
    .src2   (alu_src2),
    .imm    (alu_imm),
    .result (alu_result)
  );

endmodule

// File: instr_mem.sv
`timescale 1ns/1ns

module instr_mem #(
  parameter int im_addr_w = 10
) (
  input  logic                 clk,
  input  logic                 im_write,
  input  logic [im_addr_w-1:0] im_waddr,
  input  logic [31:0]          im_wdata,
  input  logic                 im_read,
  input  logic [im_addr_w-1:0] im_raddr,
  output logic [31:0]          im_rdata
);

  logic [31:0] mem [2**im_addr_w];

  // Loader side
  always_ff @(posedge clk) begin
    if (im_write) begin
      mem[im_waddr] <= im_wdata;
    end
  end

  // The controller read port holds its data between fetches
  always_ff @(posedge clk) begin
    if (im_read) begin
      im_rdata <= mem[im_raddr];
    end
  end

endmodule

// File: ir_controller.sv
`timescale 1ns/1ns

module ir_controller #(
  parameter int im_addr_w = 10,
  parameter int dm_addr_w = 12
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                system_enable,
  input  logic                                load_done,
  input  logic [im_addr_w:0]                  total_ir,
  input  logic [cpu_isa_pkg::data_w-1:0]      im_rdata,
  input  logic [cpu_isa_pkg::data_w-1:0]      read_data1,
  input  logic [cpu_isa_pkg::data_w-1:0]      read_data2,
  input  logic [cpu_isa_pkg::data_w-1:0]      alu_result,
  input  logic [cpu_isa_pkg::data_w-1:0]      dm_out,
  output logic                                im_read,
  output logic [im_addr_w-1:0]                im_raddr,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  reg_raddr1,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  reg_raddr2,
  output logic                                reg_write,
  output logic [cpu_isa_pkg::reg_addr_w-1:0]  reg_waddr,
  output logic [cpu_isa_pkg::data_w-1:0]      reg_wdata,
  output cpu_isa_pkg::opcode_e                alu_op,
  output cpu_isa_pkg::sub_op_e                alu_sub_op,
  output logic [cpu_isa_pkg::data_w-1:0]      alu_src1,
  output logic [cpu_isa_pkg::data_w-1:0]      alu_src2,
  output logic [cpu_isa_pkg::data_w-1:0]      alu_imm,
  output logic                                dm_enable,
  output logic                                dm_read,
  output logic                                dm_write,
  output logic [dm_addr_w-1:0]                dm_address,
  output logic [cpu_isa_pkg::data_w-1:0]      dm_in,
  output logic [cpu_ctrl_pkg::cycle_w-1:0]    cycle_cnt,
  output logic [cpu_ctrl_pkg::ins_w-1:0]      ins_cnt,
  output logic                                run_active,
  output logic                                done
);
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  exec_state_e           state;
  logic [im_addr_w-1:0]  pc;
  logic [data_w-1:0]     ir;
  logic [data_w-1:0]     alu_q;
  opcode_e               op;
  logic [imm_w-1:0]      imm;
  logic                  is_mem;

  ////////////////////
  // Decode
  ////////////////////
  assign op         = opcode_e'(ir[op_lsb +: op_w]);
  assign imm        = ir[imm_w-1:0];
  assign is_mem     = (op == op_lwi) || (op == op_swi);
  assign alu_op     = op;
  assign alu_sub_op = sub_op_e'(ir[sub_w-1:0]);
  assign alu_imm    = (op == op_ori) ? {{(data_w-imm_w){1'b0}}, imm}
                                     : {{(data_w-imm_w){imm[imm_w-1]}}, imm};
  assign alu_src1   = read_data1;
  assign alu_src2   = read_data2;

  assign reg_raddr1 = ir[ra_lsb +: reg_addr_w];
  // A store reads its data register through the second port
  assign reg_raddr2 = (op == op_swi) ? ir[rt_lsb +: reg_addr_w] : ir[rb_lsb +: reg_addr_w];
  assign reg_waddr  = ir[rt_lsb +: reg_addr_w];
  assign reg_wdata  = (op == op_lwi) ? dm_out : alu_q;
  assign reg_write  = (state == ex_write) && (op != op_swi);

  assign im_read    = (state == ex_fetch);
  assign im_raddr   = pc;
  assign dm_enable  = (state == ex_mem) && is_mem;
  assign dm_read    = (state == ex_mem) && (op == op_lwi);
  assign dm_write   = (state == ex_mem) && (op == op_swi);
  assign dm_address = alu_q[dm_addr_w-1:0];
  assign dm_in      = read_data2;
  assign run_active = (state != ex_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ex_idle;
      pc      <= '0;
      ins_cnt <= '0;
      done    <= 1'b0;
    end else begin
      case (state)
        ex_idle: begin
          if (system_enable) done <= 1'b0;
          if (load_done) begin
            pc      <= '0;
            ins_cnt <= '0;
            state   <= ex_fetch;
          end
        end
        ex_fetch:   state <= ex_decode;
        ex_decode:  state <= ex_execute;
        ex_execute: state <= ex_mem;
        ex_mem:     state <= ex_write;
        ex_write: begin
          ins_cnt <= ins_cnt + 1'b1;
          pc      <= pc + 1'b1;
          if (ins_cnt + 1'b1 == ins_w'(total_ir)) begin
            done  <= 1'b1;
            state <= ex_idle;
          end else begin
            state <= ex_fetch;
          end
        end
        default: state <= ex_idle;
      endcase
    end
  end

  // The instruction register loads in decode and the ALU result in execute
  always_ff @(posedge clk) begin
    if (state == ex_decode) ir <= im_rdata;
    if (state == ex_execute) alu_q <= alu_result; // Address or writeback value
  end

endmodule

// File: list.f
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
rom_loader.sv
instr_mem.sv
ir_controller.sv
regfile.sv
alu32.sv
cpu_top.sv
tb_cpu_top.sv

// File: regfile.sv
`timescale 1ns/1ns

module regfile (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0] raddr1,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0] raddr2,
  input  logic                               write,
  input  logic [cpu_isa_pkg::reg_addr_w-1:0] waddr,
  input  logic [cpu_isa_pkg::data_w-1:0]     wdata,
  output logic [cpu_isa_pkg::data_w-1:0]     read_data1,
  output logic [cpu_isa_pkg::data_w-1:0]     read_data2
);
  import cpu_isa_pkg::*;

  logic [data_w-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (write && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Register 0 is hardwired to zero
  assign read_data1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign read_data2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rom_loader.sv
`timescale 1ns/1ns

module rom_loader #(
  parameter int im_addr_w  = 10,
  parameter int rom_addr_w = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  system_enable,
  input  logic                  run_active,
  input  logic [32:0]           rom_out,
  output logic                  rom_enable,
  output logic                  rom_read,
  output logic [rom_addr_w-1:0] rom_address,
  output logic                  im_write,
  output logic [im_addr_w-1:0]  im_waddr,
  output logic [31:0]           im_wdata,
  output logic                  load_done,
  output logic [im_addr_w:0]    total_ir
);
  import cpu_ctrl_pkg::*;

  load_state_e        state;
  logic [im_addr_w:0] word_cnt;
  logic               eop;

  assign eop        = rom_out[32]; // Set on the last word of the program
  assign rom_enable = (state == ld_read);
  assign rom_read   = (state == ld_read);
  assign im_write   = (state == ld_write);
  assign im_waddr   = word_cnt[im_addr_w-1:0];
  assign im_wdata   = rom_out[31:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ld_idle;
      rom_address <= '0;
      word_cnt    <= '0;
      load_done   <= 1'b0;
      total_ir    <= '0;
    end else begin
      load_done <= 1'b0;
      case (state)
        ld_idle: begin
          // A new load would overwrite the program still being run
          if (system_enable && !run_active && !load_done) begin
            rom_address <= '0;
            word_cnt    <= '0;
            state       <= ld_read;
          end
        end
        ld_read: state <= ld_write; // ROM data shows up next cycle
        ld_write: begin
          if (eop) begin
            load_done <= 1'b1;
            total_ir  <= word_cnt + 1'b1;
            state     <= ld_idle;
          end else begin
            rom_address <= rom_address + 1'b1;
            word_cnt    <= word_cnt + 1'b1;
            state       <= ld_read;
          end
        end
        default: state <= ld_idle;
      endcase
    end
  end

endmodule

// File: tb_cpu_top.sv
`timescale 1ns/1ns

module tb_cpu_top;
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  localparam int im_addr_w  = 10;
  localparam int rom_addr_w = 8;
  localparam int dm_addr_w  = 12;

  localparam int reset_cycles = 8;

  // Words in each test program in the order the tests run
  localparam int prog_words     = 12 + 14 + 8 + 3 + 2;
  localparam int timeout_cycles = 2 * (2 * prog_words + 5 * prog_words) + 200;

  logic                   clk;
  logic                   rst           = 1'b1;
  logic                   system_enable = 1'b0;
  logic [data_w:0]        rom_out       = '0;
  logic [data_w-1:0]      dm_out        = '0;
  logic                   rom_enable;
  logic                   rom_read;
  logic [rom_addr_w-1:0]  rom_address;
  logic                   dm_enable;
  logic                   dm_read;
  logic                   dm_write;
  logic [dm_addr_w-1:0]   dm_address;
  logic [data_w-1:0]      dm_in;
  logic [cycle_w-1:0]     cycle_cnt;
  logic [ins_w-1:0]       ins_cnt;
  logic                   done;

  logic [data_w:0]        rom [2**rom_addr_w];
  logic [data_w-1:0]      dmem [2**dm_addr_w];
  logic [data_w-1:0]      ref_regs [2**reg_addr_w];
  logic [data_w-1:0]      prog [$];
  logic [dm_addr_w-1:0]   exp_addr [$];
  logic [data_w-1:0]      exp_data [$];
  logic [dm_addr_w-1:0]   log_addr [$];
  logic [data_w-1:0]      log_data [$];
  logic [31:0]            lfsr   = 32'hb415_1ed1;
  int                     cycles = 0;

  cpu_top #(
    .im_addr_w  (im_addr_w),
    .rom_addr_w (rom_addr_w),
    .dm_addr_w  (dm_addr_w)
  ) cpu_top_i (
    .clk           (clk),
    .rst           (rst),
    .system_enable (system_enable),
    .rom_out       (rom_out),
    .dm_out        (dm_out),
    .rom_enable    (rom_enable),
    .rom_read      (rom_read),
    .rom_address   (rom_address),
    .dm_enable     (dm_enable),
    .dm_read       (dm_read),
    .dm_write      (dm_write),
    .dm_address    (dm_address),
    .dm_in         (dm_in),
    .cycle_cnt     (cycle_cnt),
    .ins_cnt       (ins_cnt),
    .done          (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Memory models
  ////////////////////
  always @(posedge clk) begin
    if (rom_enable && rom_read) rom_out <= rom[rom_address];
  end

  // Loads come from preloaded words and stores only go to the log
  always @(posedge clk) begin
    if (dm_enable && dm_read) dm_out <= dmem[dm_address];
  end

  always @(posedge clk) begin
    if (dm_write) begin
      if (done) begin
        abort_run("A data memory write happened while done was high");
      end else begin
        log_addr.push_back(dm_address);
        log_data.push_back(dm_in);
      end
    end
  end

  always @(posedge clk) begin
    if (cycles >= timeout_cycles) begin
      abort_run($sformatf("Timeout after %0d cycles without finishing", cycles));
    end else begin
      cycles <= cycles + 1;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_data(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input logic [dm_addr_w-1:0] exp,
                            input logic [dm_addr_w-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input logic [ins_w-1:0] exp,
                             input logic [ins_w-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_cycles(input string name, input logic [cycle_w-1:0] exp,
                              input logic [cycle_w-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  // Galois LFSR stepped once for every bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
      val  = {val[30:0], lsb};
    end
    return val;
  endfunction

  ////////////////////
  // Program builder and reference model
  ////////////////////
  task automatic imm_op(input opcode_e op, input logic [reg_addr_w-1:0] rt,
                        input logic [reg_addr_w-1:0] ra, input logic [imm_w-1:0] imm);
    logic [data_w-1:0] ext;
    ext = (op == op_ori) ? {17'd0, imm} : {{17{imm[imm_w-1]}}, imm}; // ori zero-extends
    prog.push_back({op, rt, ra, 1'b0, imm});
    if (rt != '0) begin
      ref_regs[rt] = (op == op_ori) ? (ref_regs[ra] | ext) : (ref_regs[ra] + ext);
    end
  endtask

  task automatic rtype_op(input sub_op_e sub, input logic [reg_addr_w-1:0] rt,
                          input logic [reg_addr_w-1:0] ra, input logic [reg_addr_w-1:0] rb);
    logic [data_w-1:0] res;
    case (sub)
      sub_add: res = ref_regs[ra] + ref_regs[rb];
      sub_sub: res = ref_regs[ra] - ref_regs[rb];
      sub_and: res = ref_regs[ra] & ref_regs[rb];
      sub_or:  res = ref_regs[ra] | ref_regs[rb];
      sub_xor: res = ref_regs[ra] ^ ref_regs[rb];
      default: res = '0;
    endcase
    prog.push_back({op_alu, rt, ra, rb, 6'd0, sub});
    if (rt != '0) ref_regs[rt] = res;
  endtask

  // Loads and stores use r0 as base, so the address is the immediate
  task automatic load_word(input logic [reg_addr_w-1:0] rt, input logic [dm_addr_w-1:0] addr);
    prog.push_back({op_lwi, rt, 5'd0, 1'b0, 3'd0, addr});
    if (rt != '0) ref_regs[rt] = dmem[addr];
  endtask

  task automatic store_word(input logic [reg_addr_w-1:0] rt, input logic [dm_addr_w-1:0] addr);
    prog.push_back({op_swi, rt, 5'd0, 1'b0, 3'd0, addr});
    exp_addr.push_back(addr);
    exp_data.push_back(ref_regs[rt]);
  endtask

  task automatic run_program();
    logic eop;
    for (int a = 0; a < 2**rom_addr_w; a++) begin
      rom[a] = {1'b0, 32'(a) ^ 32'h5a5a_0000};
    end
    foreach (prog[i]) begin
      eop    = (i == prog.size() - 1);
      rom[i] = {eop, prog[i]};
    end
    log_addr.delete();
    log_data.delete();
    @(posedge clk);
    system_enable <= 1'b1;
    @(posedge clk);
    system_enable <= 1'b0;
    do begin
      @(posedge clk);
    end while (!done);
    repeat (5) @(posedge clk); // Any late store would show up here
    if (!done) abort_run("done dropped before the next start");
    check_count("ins_cnt", ins_w'(prog.size()), ins_cnt);
    // The cycle counter starts with the first cycle after reset
    check_cycles("cycle_cnt", cycle_w'(cycles - reset_cycles), cycle_cnt);
    check_count("dm_write count", ins_w'(exp_addr.size()), ins_w'(log_addr.size()));
    foreach (exp_addr[i]) begin
      check_addr("dm_address", exp_addr[i], log_addr[i]);
      check_data("dm_in", exp_data[i], log_data[i]);
    end
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic imm_and_store();
    for (int k = 1; k <= 4; k++) begin
      imm_op(op_addi, 5'(k), 5'd0, 15'(rand_bits(15)));
      imm_op(op_ori, 5'(k), 5'(k), 15'(rand_bits(15)));
      store_word(5'(k), 12'h100 + 12'(k));
    end
    run_program();
  endtask

  task automatic reg_alu_ops();
    sub_op_e subs [5] = '{sub_add, sub_sub, sub_and, sub_or, sub_xor};
    imm_op(op_addi, 5'd5, 5'd0, 15'(rand_bits(15)));
    imm_op(op_ori, 5'd5, 5'd5, 15'(rand_bits(15)));
    imm_op(op_addi, 5'd6, 5'd0, 15'(rand_bits(15)));
    imm_op(op_ori, 5'd6, 5'd6, 15'(rand_bits(15)));
    for (int i = 0; i < 5; i++) begin
      rtype_op(subs[i], 5'(10 + i), 5'd5, 5'd6);
      store_word(5'(10 + i), 12'h200 + 12'(i));
    end
    run_program();
  endtask

  task automatic load_then_use();
    for (int j = 0; j < 2; j++) begin
      dmem[12'h800 + 12'(2 * j)] = rand_bits(32);
      dmem[12'h801 + 12'(2 * j)] = rand_bits(32);
      load_word(5'd20, 12'h800 + 12'(2 * j));
      load_word(5'd21, 12'h801 + 12'(2 * j));
      rtype_op(sub_add, 5'd22, 5'd20, 5'd21);
      store_word(5'd22, 12'h280 + 12'(j));
    end
    run_program();
  endtask

  task automatic zero_register();
    imm_op(op_addi, 5'd0, 5'd0, 15'(rand_bits(15)) | 15'h1);
    rtype_op(sub_add, 5'd0, 5'd5, 5'd6);
    store_word(5'd0, 12'h300);
    run_program();
  endtask

  // Shorter than the program before it, so stale words stay behind in the buffer
  task automatic restart_run();
    imm_op(op_ori, 5'd7, 5'd0, 15'(rand_bits(15)));
    store_word(5'd7, 12'h3c0);
    run_program();
  endtask

  initial begin
    for (int r = 0; r < 2**reg_addr_w; r++) begin
      ref_regs[r] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    imm_and_store();
    reg_alu_ops();
    load_then_use();
    zero_register();
    restart_run();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
